/* verilog/nocPkg.sv */
package nocPkg;

  // Router ports in arbiter rotation order
  localparam int portCount = 5;

  typedef logic [2:0] portIdx;

  localparam portIdx portL = 3'd0;
  localparam portIdx portN = 3'd1;
  localparam portIdx portE = 3'd2;
  localparam portIdx portW = 3'd3;
  localparam portIdx portS = 3'd4;

  typedef enum logic [2:0] {
    kindHead = 3'd1,
    kindBody = 3'd2,
    kindTail = 3'd3
  } flitKindT;

  // 4 by 4 mesh
  localparam int coordW = 2;
  localparam int lengthW = 12;

  // Entries per input buffer
  localparam int fifoDepth = 4;

  typedef struct packed {
    logic [coordW-1:0]  destX;
    logic [coordW-1:0]  destY;
    logic [lengthW-1:0] length;
    logic [15:0]        srcId;
  } headFieldsT;

  // Same word seen as head fields or body data
  typedef union packed {
    headFieldsT  head;
    logic [31:0] data;
  } flitPayloadU;

  typedef struct packed {
    flitKindT    kind;
    flitPayloadU payload;
  } flitT;

endpackage

/* verilog/portTimer.sv */
`timescale 1ns/1ps

module portTimer
(
  input  logic         clk,
  input  logic         rst,
  input  nocPkg::flitT headFlit,
  input  logic         headValid,
  input  logic         run,
  output logic         timesup
);
  import nocPkg::*;

  logic [lengthW-1:0] limit;
  logic [lengthW-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      // Hold budget comes with each new packet
      if (headValid && headFlit.kind == kindHead)
      begin
        limit <= headFlit.payload.head.length;
      end
      if (run)
      begin
        count <= count + 1'b1;
      end
      else
      begin
        count <= '0;
      end
    end
  end

  assign timesup = (count == limit);

endmodule

/* verilog/switchArbiter.sv */
`timescale 1ns/1ps

module switchArbiter
(
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic [nocPkg::portCount-1:0]          req,
  input  nocPkg::flitT [nocPkg::portCount-1:0]  headFlit,
  input  logic [nocPkg::portCount-1:0]          headValid,
  output logic [nocPkg::portCount-1:0]          grant
);
  import nocPkg::*;

  logic                 idle;
  portIdx               owner;
  logic                 nextIdle;
  portIdx               nextOwner;
  logic [portCount-1:0] nextGrant;
  logic                 hold;
  logic [portCount-1:0] runVec;
  logic [portCount-1:0] timesup;

  genvar i;
  generate
    for (i = 0; i < portCount; i++)
    begin : g_timer
      portTimer i_timer
      (
        .clk       (clk),
        .rst       (rst),
        .headFlit  (headFlit[i]),
        .headValid (headValid[i]),
        .run       (runVec[i]),
        .timesup   (timesup[i])
      );
    end
  endgenerate

  always_comb
  begin : nextGrantLogic
    int   base;
    int   cand;
    logic found;
    base = 0;
    cand = 0;
    found = 1'b0;
    nextIdle = 1'b1;
    nextOwner = owner;
    // Owner keeps the output until it stops asking or its budget runs out
    hold = !idle && req[owner] && !timesup[owner];
    if (hold)
    begin
      nextIdle = 1'b0;
    end
    else
    begin
      // Search from the port after the owner, or from Local when idle
      base = idle ? int'(portL) : int'(owner) + 1;
      for (int k = 0; k < portCount; k++)
      begin
        cand = (base + k) % portCount;
        if (!found && req[cand] && (idle || cand != int'(owner)))
        begin
          found = 1'b1;
          nextIdle = 1'b0;
          nextOwner = portIdx'(cand);
        end
      end
    end
    nextGrant = '0;
    nextGrant[nextOwner] = !nextIdle;
  end

  // Only the holding owner's timer counts
  assign runVec = hold ? grant : '0;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      idle <= 1'b1;
      owner <= portL;
      grant <= '0;
    end
    else
    begin
      idle <= nextIdle;
      owner <= nextOwner;
      grant <= nextGrant;
    end
  end

endmodule

/* verilog/inputPort.sv */
`timescale 1ns/1ps

module inputPort
#(
  parameter logic [nocPkg::coordW-1:0] routerX = '0,
  parameter logic [nocPkg::coordW-1:0] routerY = '0
)
(
  input  logic                         clk,
  input  logic                         rst,
  input  nocPkg::flitT                 inFlit,
  input  logic                         inValid,
  output logic                         inReady,
  input  logic                         pop,
  output nocPkg::flitT                 headFlit,
  output logic                         headValid,
  output logic [nocPkg::portCount-1:0] reqVec
);
  import nocPkg::*;

  flitT                             mem [fifoDepth];
  logic [$clog2(fifoDepth)-1:0]     wrPtr;
  logic [$clog2(fifoDepth)-1:0]     rdPtr;
  logic [$clog2(fifoDepth+1)-1:0]   count;
  logic                             push;
  logic                             frontIsHead;
  logic [portCount-1:0]             routeNow;
  logic [portCount-1:0]             routeReg;

  assign inReady = (count != fifoDepth);
  assign push = inValid && inReady;
  assign headValid = (count != '0);
  assign headFlit = mem[rdPtr];
  assign frontIsHead = headValid && headFlit.kind == kindHead;

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      mem[wrPtr] <= inFlit;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
      begin
        wrPtr <= (wrPtr == fifoDepth - 1) ? '0 : wrPtr + 1'b1;
      end
      if (pop)
      begin
        rdPtr <= (rdPtr == fifoDepth - 1) ? '0 : rdPtr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // XY routing with X resolved first
  always_comb
  begin
    routeNow = '0;
    if (headFlit.payload.head.destX > routerX)
      routeNow[portE] = 1'b1;
    else if (headFlit.payload.head.destX < routerX)
      routeNow[portW] = 1'b1;
    else if (headFlit.payload.head.destY > routerY)
      routeNow[portS] = 1'b1;
    else if (headFlit.payload.head.destY < routerY)
      routeNow[portN] = 1'b1;
    else
      routeNow[portL] = 1'b1;
  end

  // Body and tail flits follow their head's output
  always_ff @(posedge clk)
  begin
    if (rst)
      routeReg <= '0;
    else if (frontIsHead)
      routeReg <= routeNow;
    else if (pop && headFlit.kind == kindTail)
      routeReg <= '0;
  end

  assign reqVec = !headValid ? '0 : (frontIsHead ? routeNow : routeReg);

endmodule

/* verilog/outputPort.sv */
`timescale 1ns/1ps

module outputPort
(
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic [nocPkg::portCount-1:0]          req,
  input  nocPkg::flitT [nocPkg::portCount-1:0]  headFlit,
  input  logic [nocPkg::portCount-1:0]          headValid,
  output logic [nocPkg::portCount-1:0]          pop,
  output nocPkg::flitT                          outFlit,
  output logic                                  outValid,
  input  logic                                  outReady
);
  import nocPkg::*;

  logic [portCount-1:0] grant;
  logic                 space;
  flitT                 selFlit;

  switchArbiter i_arbiter
  (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .headFlit  (headFlit),
    .headValid (headValid),
    .grant     (grant)
  );

  // Register is free, or empties on this edge
  assign space = !outValid || outReady;

  // Grant is one edge old, so the input must still be asking
  assign pop = grant & req & {portCount{space}};

  always_comb
  begin
    selFlit = '0;
    for (int i = 0; i < portCount; i++)
    begin
      if (grant[i])
      begin
        selFlit = headFlit[i];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else if (|pop)
      outValid <= 1'b1;
    else if (outReady)
      outValid <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (|pop)
    begin
      outFlit <= selFlit;
    end
  end

endmodule

/* verilog/nocRouter.sv */
`timescale 1ns/1ps

module nocRouter
#(
  parameter logic [nocPkg::coordW-1:0] routerX = '0,
  parameter logic [nocPkg::coordW-1:0] routerY = '0
)
(
  input  logic                                  clk,
  input  logic                                  rst,
  input  nocPkg::flitT [nocPkg::portCount-1:0]  inFlit,
  input  logic [nocPkg::portCount-1:0]          inValid,
  output logic [nocPkg::portCount-1:0]          inReady,
  output nocPkg::flitT [nocPkg::portCount-1:0]  outFlit,
  output logic [nocPkg::portCount-1:0]          outValid,
  input  logic [nocPkg::portCount-1:0]          outReady
);
  import nocPkg::*;

  flitT [portCount-1:0]                 headFlit;
  logic [portCount-1:0]                 headValid;
  logic [portCount-1:0]                 inPop;
  // Indexed [input][output]
  logic [portCount-1:0][portCount-1:0]  reqVec;
  logic [portCount-1:0][portCount-1:0]  popIn;
  // Indexed [output][input]
  logic [portCount-1:0][portCount-1:0]  reqOut;
  logic [portCount-1:0][portCount-1:0]  popOut;

  genvar i, k;
  generate
    for (i = 0; i < portCount; i++)
    begin : g_port
      inputPort #(.routerX(routerX), .routerY(routerY)) i_input
      (
        .clk       (clk),
        .rst       (rst),
        .inFlit    (inFlit[i]),
        .inValid   (inValid[i]),
        .inReady   (inReady[i]),
        .pop       (inPop[i]),
        .headFlit  (headFlit[i]),
        .headValid (headValid[i]),
        .reqVec    (reqVec[i])
      );

      outputPort i_output
      (
        .clk       (clk),
        .rst       (rst),
        .req       (reqOut[i]),
        .headFlit  (headFlit),
        .headValid (headValid),
        .pop       (popOut[i]),
        .outFlit   (outFlit[i]),
        .outValid  (outValid[i]),
        .outReady  (outReady[i])
      );

      for (k = 0; k < portCount; k++)
      begin : g_cross
        assign reqOut[k][i] = reqVec[i][k];
        assign popIn[i][k] = popOut[k][i];
      end

      assign inPop[i] = |popIn[i];
    end
  endgenerate

endmodule

/* testbench/nocRouterTb.sv */
`timescale 1ns/1ps

module nocRouterTb;
  import nocPkg::*;

  typedef struct packed {
    flitT   flit;
    portIdx port;
    logic   isShort;
  } expT;

  logic                  clk;
  logic                  rst;
  flitT [portCount-1:0]  inFlit;
  logic [portCount-1:0]  inValid;
  logic [portCount-1:0]  inReady;
  flitT [portCount-1:0]  outFlit;
  logic [portCount-1:0]  outValid;
  logic [portCount-1:0]  outReady;

  logic [51:0] pattern [0:63];
  flitT        sendQ [portCount][$];
  expT         expQ [portCount][$];
  portIdx      curSrc [portCount];
  int          headCount [portCount];
  portIdx      headOrder [$];
  int          phase;
  logic        randomReady;
  integer      seed;
  string       testName;

  nocRouter #(.routerX(2'd1), .routerY(2'd1)) i_dut
  (
    .clk      (clk),
    .rst      (rst),
    .inFlit   (inFlit),
    .inValid  (inValid),
    .inReady  (inReady),
    .outFlit  (outFlit),
    .outValid (outValid),
    .outReady (outReady)
  );

  always #4 clk = !clk;

  task automatic stopOnError();
    $display("Something failed");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic checkFlit(string name, flitT expected, flitT actual);
    if (actual !== expected)
    begin
      $display("FAILED %s expected flit %h actual flit %h", name, expected, actual);
      stopOnError();
    end
  endtask

  task automatic checkPort(string name, portIdx expected, portIdx actual);
    if (actual !== expected)
    begin
      $display("FAILED %s expected port %0d actual port %0d", name, expected, actual);
      stopOnError();
    end
  endtask

  task automatic checkMask(string name, logic [portCount-1:0] expected,
                           logic [portCount-1:0] actual);
    if (actual !== expected)
    begin
      $display("FAILED %s expected mask %b actual mask %b", name, expected, actual);
      stopOnError();
    end
  endtask

  // Match an output flit against the expected queue of its source
  task automatic handleOut(int o, flitT f);
    int   src;
    expT  e;
    src = curSrc[o];
    if (f.kind == kindHead)
    begin
      src = f.payload.head.srcId[2:0];
      curSrc[o] = portIdx'(src);
      headCount[o]++;
      if (phase == 3 && o == portW)
        headOrder.push_back(portIdx'(src));
    end
    else if (expQ[src].size() == 0 || expQ[src][0].flit !== f)
    begin
      // Interrupted packet resumes after another one
      for (int s = 0; s < portCount; s++)
      begin
        if (expQ[s].size() > 0 && expQ[s][0].flit === f && expQ[s][0].port == o)
        begin
          if (!expQ[s][0].isShort)
          begin
            $display("Packet from input %0d was broken up on output %0d in %s",
                     s, o, testName);
            stopOnError();
          end
          src = s;
          curSrc[o] = portIdx'(s);
        end
      end
    end
    if (expQ[src].size() == 0)
    begin
      $display("Output %0d delivered an unexpected flit %h in %s", o, f, testName);
      stopOnError();
    end
    e = expQ[src].pop_front();
    checkFlit(testName, e.flit, f);
    checkPort(testName, e.port, portIdx'(o));
    if (phase == 4 && f.kind == kindTail && e.isShort && headCount[o] < 2)
    begin
      $display("Waiting packet did not pass the long packet on output %0d", o);
      stopOnError();
    end
  endtask

  // Sample transfers at the edge and drive new values 1 ns later
  always @(posedge clk)
  begin : drivers
    logic [portCount-1:0] fired;
    logic [portCount-1:0] gone;
    flitT [portCount-1:0] seen;
    fired = inValid & inReady;
    gone = outValid & outReady;
    seen = outFlit;
    for (int o = 0; o < portCount; o++)
    begin
      if (!rst && gone[o])
        handleOut(o, seen[o]);
    end
    #1;
    for (int p = 0; p < portCount; p++)
    begin
      if (fired[p])
        void'(sendQ[p].pop_front());
      inValid[p] = (sendQ[p].size() > 0);
      inFlit[p] = (sendQ[p].size() > 0) ? sendQ[p][0] : '0;
      outReady[p] = randomReady ? $random(seed) : 1'b1;
    end
  end

  task automatic loadPhase(int p);
    flitT f;
    expT  e;
    int   src;
    for (int i = 0; i < 64; i++)
    begin
      if (pattern[i][51:48] == p)
      begin
        src = pattern[i][47:44];
        f.kind = flitKindT'(pattern[i][42:40]);
        f.payload.data = pattern[i][39:8];
        e.flit = f;
        e.port = portIdx'(pattern[i][7:4]);
        e.isShort = pattern[i][0];
        sendQ[src].push_back(f);
        expQ[src].push_back(e);
      end
    end
  endtask

  task automatic waitDrained();
    int   cycles;
    logic busy;
    cycles = 0;
    busy = 1'b1;
    while (busy)
    begin
      @(negedge clk);
      busy = (outValid != '0);
      for (int p = 0; p < portCount; p++)
      begin
        if (sendQ[p].size() > 0 || expQ[p].size() > 0)
          busy = 1'b1;
      end
      cycles++;
      if (busy && cycles > 3000)
      begin
        $display("Router stopped delivering flits in %s", testName);
        stopOnError();
      end
    end
  endtask

  task automatic runPhase(int p, string name);
    testName = name;
    phase = p;
    headOrder.delete();
    for (int o = 0; o < portCount; o++)
      headCount[o] = 0;
    loadPhase(p);
    waitDrained();
  endtask

  initial
  begin
    clk = 1'b0;
    rst = 1'b1;
    inFlit = '0;
    inValid = '0;
    outReady = '1;
    randomReady = 1'b0;
    seed = 95;
    phase = 0;
    testName = "reset";
    for (int i = 0; i < 64; i++)
      pattern[i] = '0;
    $readmemh("testbench/nocRouterPatterns.txt", pattern);

    repeat (16) @(posedge clk);
    #1 rst = 1'b0;

    // Quiet router after reset
    repeat (20)
    begin
      @(negedge clk);
      checkMask("reset outValid", '0, outValid);
      checkMask("reset inReady", '1, inReady);
    end

    runPhase(1, "xy routing");
    runPhase(2, "stream order");
    runPhase(3, "rotation");
    if (headOrder.size() != 3)
    begin
      $display("West output saw %0d packet heads instead of 3", headOrder.size());
      stopOnError();
    end
    checkPort("rotation first", portL, headOrder[0]);
    checkPort("rotation second", portE, headOrder[1]);
    checkPort("rotation third", portS, headOrder[2]);
    runPhase(4, "timeout release");
    randomReady = 1'b1;
    runPhase(5, "back-pressure");

    $display("Everything OK");
    $finish;
  end

endmodule

/* nocRouter.f */
verilog/nocPkg.sv
verilog/portTimer.sv
verilog/switchArbiter.sv
verilog/inputPort.sv
verilog/outputPort.sv
verilog/nocRouter.sv
testbench/nocRouterTb.sv

/* testbench/nocRouterPatterns.txt */
// Columns: phase(1) inPort(1) kind(1) payload(8) expPort(1) shortLength(1)
// Head payload: destX/destY nibble, length (3), srcId (4); srcId equals inPort
// Phase 1, XY routing from (1,1)
10150FF000000
10190FF000020
10110FF000030
10160FF000040
10140FF000010
141F0FF000420
13170FF000340
// Phase 2, stream order
211D0FF000120
2120000210120
2120000210220
2130000210320
22150FF000200
2220000220100
2230000220200
// Phase 3, rotation towards West
30100FF000030
3020000300130
3030000300230
32120FF000230
3220000320130
3230000320230
34130FF000430
3420000340130
3430000340230
// Phase 4, timeout release on East
401A002000021
4020000400121
4020000400221
4020000400321
4020000400421
4030000400521
411C0FF000120
4120000410120
4130000410220
// Phase 5, back-pressure mix
50170FF000040
5020000500140
5030000500240
50190FF000020
5030000500320
51160FF000140
5120000510140
5130000510240
52110FF000230
5230000520130
53150FF000300
5320000530100
5320000530200
5330000530300
54140FF000410
